// ==== build.f ====
common/io_fabric_pkg.sv
hdl/port_decode.sv
hdl/sysctl_port.sv
hdl/readdata_mux.sv
hdl/mgmt_select.sv
hdl/io_fabric.sv
dv/io_fabric_chk.sv
dv/io_fabric_tb.sv

// ==== common/io_fabric_pkg.sv ====
package io_fabric_pkg;

	localparam int DEV_COUNT = 21;

	typedef logic [15:0]          io_addr_t;
	typedef logic [7:0]           byte_t;
	typedef logic [31:0]          word_t;
	typedef logic [2:0]           dsize_t;
	typedef logic [DEV_COUNT-1:0] dev_sel_t;

	localparam int SEL_HDD0       = 0;
	localparam int SEL_HDD1       = 1;
	localparam int SEL_FLOPPY     = 2;
	localparam int SEL_JOY        = 3;
	localparam int SEL_DMA_MASTER = 4;
	localparam int SEL_DMA_PAGE   = 5;
	localparam int SEL_DMA_SLAVE  = 6;
	localparam int SEL_PIC_MASTER = 7;
	localparam int SEL_PIC_SLAVE  = 8;
	localparam int SEL_PIT        = 9;
	localparam int SEL_PS2_IO     = 10;
	localparam int SEL_PS2_CTL    = 11;
	localparam int SEL_RTC        = 12;
	localparam int SEL_FM         = 13;
	localparam int SEL_SB         = 14;
	localparam int SEL_UART       = 15;
	localparam int SEL_MPU        = 16;
	localparam int SEL_VGA_B      = 17;
	localparam int SEL_VGA_C      = 18;
	localparam int SEL_VGA_D      = 19;
	localparam int SEL_SYSCTL     = 20;

	// port bases, block size noted where the decode masks low bits
	localparam io_addr_t PORT_HDD0       = 16'h01F0; // /8
	localparam io_addr_t PORT_HDD0_CTL   = 16'h03F6;
	localparam io_addr_t PORT_HDD1       = 16'h0170; // /8
	localparam io_addr_t PORT_HDD1_CTL   = 16'h0376;
	localparam io_addr_t PORT_JOY        = 16'h0201;
	localparam io_addr_t PORT_FLOPPY     = 16'h03F0; // /8
	localparam io_addr_t PORT_DMA_MASTER = 16'h00C0; // /32
	localparam io_addr_t PORT_DMA_PAGE   = 16'h0080; // /16
	localparam io_addr_t PORT_DMA_SLAVE  = 16'h0000; // /16
	localparam io_addr_t PORT_PIC_MASTER = 16'h0020; // /2
	localparam io_addr_t PORT_PIC_SLAVE  = 16'h00A0; // /2
	localparam io_addr_t PORT_PIT        = 16'h0040; // /4
	localparam io_addr_t PORT_PIT_SPKR   = 16'h0061; // speaker gate
	localparam io_addr_t PORT_PS2_IO     = 16'h0060; // /8
	localparam io_addr_t PORT_PS2_CTL    = 16'h0090; // /16
	localparam io_addr_t PORT_RTC        = 16'h0070; // /2
	localparam io_addr_t PORT_FM         = 16'h0388; // /4
	localparam io_addr_t PORT_SB         = 16'h0220; // /16
	localparam io_addr_t PORT_UART       = 16'h03F8; // /8
	localparam io_addr_t PORT_MPU        = 16'h0330; // /2
	localparam io_addr_t PORT_VGA_B      = 16'h03B0; // /16
	localparam io_addr_t PORT_VGA_C      = 16'h03C0; // /16
	localparam io_addr_t PORT_VGA_D      = 16'h03D0; // /16
	localparam io_addr_t PORT_SYSCTL     = 16'h8888;

	localparam byte_t SYSCTL_KEY = 8'hA1; // high byte of a config write

	// management address high byte codes
	localparam byte_t MGMT_HDD0 = 8'hF0;
	localparam byte_t MGMT_HDD1 = 8'hF1;
	localparam byte_t MGMT_FDD  = 8'hF2;
	localparam byte_t MGMT_RTC  = 8'hF4;

	typedef enum logic {
		ST_BOOT,
		ST_RUN
	} sysctl_state_t;

endpackage

// ==== dv/io_fabric_chk.sv ====
`timescale 1ns/1ps

module io_fabric_chk #(
	parameter io_fabric_pkg::byte_t SYSCFG_INIT = 8'hA2
) (
	input logic                    clk_sys,
	input logic                    reset,
	input logic                    io32,
	input io_fabric_pkg::dev_sel_t dev_sel,
	input io_fabric_pkg::byte_t    syscfg,
	input logic [3:0]              mgmt_sel
);

	logic wide_sel;

	assign wide_sel = dev_sel[io_fabric_pkg::SEL_HDD0] | dev_sel[io_fabric_pkg::SEL_HDD1] |
	                  dev_sel[io_fabric_pkg::SEL_SYSCTL]; // only 32-bit capable ports

	boot_value: assert property (@(posedge clk_sys) reset |=> syscfg == SYSCFG_INIT)
		else $error("syscfg not at its boot value after reset");

	io32_source: assert property (@(posedge clk_sys) disable iff (reset) io32 |-> wide_sel)
		else $error("io32 high without a disk or config port select");

	mgmt_onehot: assert property (@(posedge clk_sys) disable iff (reset) $onehot0(mgmt_sel))
		else $error("more than one management select active");

endmodule

bind io_fabric io_fabric_chk #(.SYSCFG_INIT(SYSCFG_INIT)) u_chk (
	.clk_sys  (clk_sys),
	.reset    (reset),
	.io32     (io32),
	.dev_sel  (dev_sel),
	.syscfg   (syscfg),
	.mgmt_sel (mgmt_sel)
);

// ==== dv/io_fabric_tb.sv ====
`timescale 1ns/1ps

module io_fabric_tb;

	localparam io_fabric_pkg::byte_t CFG_INIT = 8'hA2;
	localparam io_fabric_pkg::word_t HDD0_D   = 32'h1D00_0A0A;
	localparam io_fabric_pkg::word_t HDD1_D   = 32'h1D11_0B0B;
	localparam io_fabric_pkg::byte_t FDD_D    = 8'h31;
	localparam io_fabric_pkg::byte_t DMA_D    = 8'h42;
	localparam io_fabric_pkg::byte_t PIC_D    = 8'h53;
	localparam io_fabric_pkg::byte_t PIT_D    = 8'h64;
	localparam io_fabric_pkg::byte_t PS2_D    = 8'h75;
	localparam io_fabric_pkg::byte_t RTC_D    = 8'h86;
	localparam io_fabric_pkg::byte_t SND_D    = 8'h97;
	localparam io_fabric_pkg::byte_t UART_D   = 8'hA8;
	localparam io_fabric_pkg::byte_t VGA_D    = 8'hB9;
	localparam io_fabric_pkg::byte_t JOY_D    = 8'hCA;
	localparam io_fabric_pkg::word_t MGMT0_D  = 32'hE000_0001;
	localparam io_fabric_pkg::word_t MGMT1_D  = 32'hE111_0002;
	localparam io_fabric_pkg::word_t MGMTF_D  = 32'hE222_0003;
	localparam io_fabric_pkg::word_t KEY_W    = {16'h0, io_fabric_pkg::SYSCTL_KEY, 8'h00};

	typedef struct packed {
		logic                    do_reset;
		io_fabric_pkg::io_addr_t addr;
		logic                    wr;
		io_fabric_pkg::dsize_t   size;
		io_fabric_pkg::word_t    wdata;
		io_fabric_pkg::io_addr_t maddr;
		io_fabric_pkg::word_t    exp_rd;
		logic                    exp_io32;
		io_fabric_pkg::byte_t    exp_cfg;
		logic [3:0]              exp_msel;
		io_fabric_pkg::word_t    exp_mrd;
		io_fabric_pkg::dev_sel_t exp_sel;
	} step_t;

	logic                    clk_sys;
	logic                    reset;
	io_fabric_pkg::io_addr_t io_address;
	logic                    io_write;
	io_fabric_pkg::dsize_t   io_datasize;
	io_fabric_pkg::word_t    io_writedata;
	io_fabric_pkg::io_addr_t mgmt_address;
	io_fabric_pkg::word_t    io_readdata;
	logic                    io32;
	io_fabric_pkg::dev_sel_t dev_sel;
	io_fabric_pkg::byte_t    syscfg;
	logic [3:0]              mgmt_sel;
	io_fabric_pkg::word_t    mgmt_readdata;

	step_t steps[$];
	int    errors;
	int    checks;

	io_fabric #(.SYSCFG_INIT(CFG_INIT)) u_dut (
		.clk_sys(clk_sys), .reset(reset),
		.io_address(io_address), .io_write(io_write), .io_datasize(io_datasize),
		.io_writedata(io_writedata), .io_readdata(io_readdata), .io32(io32), .dev_sel(dev_sel),
		.hdd0_readdata(HDD0_D), .hdd1_readdata(HDD1_D), .floppy_readdata(FDD_D),
		.dma_readdata(DMA_D), .pic_readdata(PIC_D), .pit_readdata(PIT_D), .ps2_readdata(PS2_D),
		.rtc_readdata(RTC_D), .sound_readdata(SND_D), .uart_readdata(UART_D),
		.vga_readdata(VGA_D), .joy_readdata(JOY_D), .syscfg(syscfg),
		.mgmt_address(mgmt_address), .mgmt_hdd0_readdata(MGMT0_D),
		.mgmt_hdd1_readdata(MGMT1_D), .mgmt_fdd_readdata(MGMTF_D),
		.mgmt_sel(mgmt_sel), .mgmt_readdata(mgmt_readdata)
	);

	always #10 clk_sys = ~clk_sys;

	function automatic void add_step(input logic rst, input io_fabric_pkg::io_addr_t addr,
			input logic wr, input io_fabric_pkg::dsize_t size, input io_fabric_pkg::word_t wdata,
			input io_fabric_pkg::io_addr_t maddr, input io_fabric_pkg::word_t exp_rd,
			input logic exp_io32, input io_fabric_pkg::byte_t exp_cfg, input logic [3:0] exp_msel,
			input io_fabric_pkg::dev_sel_t exp_sel);
		io_fabric_pkg::word_t mrd;
		mrd = exp_msel[0] ? MGMT0_D : (exp_msel[1] ? MGMT1_D : MGMTF_D); // floppy by default
		steps.push_back({rst, addr, wr, size, wdata, maddr, exp_rd, exp_io32, exp_cfg,
			exp_msel, mrd, exp_sel});
	endfunction

	task automatic compare(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		assert (got === exp) else begin
			$display("ERR %0t %s expected %h got %h", $time, name, exp, got);
			errors++;
		end
	endtask

	task automatic apply_reset();
		reset      = 1'b1;
		io_address = 16'h0300; // unmapped, keeps the boot state intact
		io_write   = 1'b0;
		repeat (2) @(posedge clk_sys);
		#2;
		reset = 1'b0;
	endtask

	task automatic wait_for_sysctl_select(output logic ok);
		int cycles;
		ok     = 1'b0;
		cycles = 0;
		while (!ok && cycles < 4) begin
			@(posedge clk_sys);
			#2;
			cycles++;
			ok = (dev_sel[io_fabric_pkg::SEL_SYSCTL] === 1'b1);
		end
		if (!ok) begin
			$display("timeout: config port select never came up at %0t", $time);
			errors++;
		end
	endtask

	task automatic run_step(input step_t s, output logic ok);
		ok = 1'b1;
		@(posedge clk_sys);
		#2;
		if (s.do_reset) begin
			apply_reset();
			@(posedge clk_sys);
			#2;
		end
		io_address   = s.addr;
		mgmt_address = s.maddr;
		io_datasize  = s.size;
		io_writedata = s.wdata;
		if (s.wr) begin
			wait_for_sysctl_select(ok); // address held a cycle before the strobe
			io_write = ok;
		end else begin
			@(posedge clk_sys);
			#2;
		end
		@(posedge clk_sys);
		#2;
		io_write = 1'b0;
		@(negedge clk_sys);
		compare("io_readdata", io_readdata, s.exp_rd);
		compare("io32", {31'd0, io32}, {31'd0, s.exp_io32});
		compare("syscfg", {24'd0, syscfg}, {24'd0, s.exp_cfg});
		compare("dev_sel", {11'd0, dev_sel}, {11'd0, s.exp_sel});
		compare("mgmt_sel", {28'd0, mgmt_sel}, {28'd0, s.exp_msel});
		compare("mgmt_readdata", mgmt_readdata, s.exp_mrd);
	endtask

	initial begin
		logic ok;
		clk_sys      = 1'b0;
		io_datasize  = 3'd0;
		io_writedata = 32'h0;
		mgmt_address = 16'h0000;
		errors       = 0;
		checks       = 0;
		ok           = 1'b1;
		// last column is the expected select vector
		// boot value, keyed write, then rejected writes
		add_step(0, 16'h8888, 0, 3'd0, 32'h0,          16'h0000, 32'hFF, 1, 8'hA2, 4'h0, 21'h100000);
		add_step(0, 16'h8888, 1, 3'd2, KEY_W | 32'h5C, 16'h0000, 32'hFF, 1, 8'h5C, 4'h0, 21'h100000);
		add_step(0, 16'h8888, 1, 3'd2, 32'h0000_B277,  16'h0000, 32'hFF, 1, 8'h5C, 4'h0, 21'h100000);
		add_step(0, 16'h8888, 1, 3'd4, KEY_W | 32'h33, 16'h0000, 32'hFF, 1, 8'h5C, 4'h0, 21'h100000);
		add_step(0, 16'h8888, 1, 3'd1, KEY_W | 32'h44, 16'h0000, 32'hFF, 1, 8'h5C, 4'h0, 21'h100000);
		// first disk access clears the boot config
		add_step(1, 16'h0300, 0, 3'd0, 32'h0,          16'h0000, 32'hFF, 0, 8'hA2, 4'h0, 21'h000000);
		add_step(0, 16'h01F0, 0, 3'd0, 32'h0,          16'h0000, HDD0_D, 1, 8'h00, 4'h0, 21'h000001);
		add_step(0, 16'h8888, 1, 3'd2, KEY_W | 32'hC3, 16'h0000, 32'hFF, 1, 8'hC3, 4'h0, 21'h100000);
		// device ranges with management pages alongside
		add_step(0, 16'h01F7, 0, 3'd0, 32'h0,          16'hF012, HDD0_D, 1, 8'hC3, 4'h1, 21'h000001);
		add_step(0, 16'h03F6, 0, 3'd0, 32'h0,          16'hF1AB, HDD0_D, 0, 8'hC3, 4'h2, 21'h000005);
		add_step(0, 16'h0170, 0, 3'd0, 32'h0,          16'hF234, HDD1_D, 1, 8'hC3, 4'h4, 21'h000002);
		add_step(0, 16'h0376, 0, 3'd0, 32'h0,          16'hF456, HDD1_D, 0, 8'hC3, 4'h8, 21'h000002);
		add_step(0, 16'h03F2, 0, 3'd0, 32'h0,          16'hF3FF, FDD_D,  0, 8'hC3, 4'h0, 21'h000004);
		add_step(0, 16'h00C4, 0, 3'd0, 32'h0,          16'h0000, DMA_D,  0, 8'hC3, 4'h0, 21'h000010);
		add_step(0, 16'h0087, 0, 3'd0, 32'h0,          16'h0000, DMA_D,  0, 8'hC3, 4'h0, 21'h000020);
		add_step(0, 16'h000F, 0, 3'd0, 32'h0,          16'h0000, DMA_D,  0, 8'hC3, 4'h0, 21'h000040);
		add_step(0, 16'h0021, 0, 3'd0, 32'h0,          16'h0000, PIC_D,  0, 8'hC3, 4'h0, 21'h000080);
		add_step(0, 16'h00A1, 0, 3'd0, 32'h0,          16'h0000, PIC_D,  0, 8'hC3, 4'h0, 21'h000100);
		add_step(0, 16'h0043, 0, 3'd0, 32'h0,          16'h0000, PIT_D,  0, 8'hC3, 4'h0, 21'h000200);
		add_step(0, 16'h0061, 0, 3'd0, 32'h0,          16'h0000, PIT_D,  0, 8'hC3, 4'h0, 21'h000600);
		add_step(0, 16'h0060, 0, 3'd0, 32'h0,          16'h0000, PS2_D,  0, 8'hC3, 4'h0, 21'h000400);
		add_step(0, 16'h0094, 0, 3'd0, 32'h0,          16'h0000, PS2_D,  0, 8'hC3, 4'h0, 21'h000800);
		add_step(0, 16'h0071, 0, 3'd0, 32'h0,          16'h0000, RTC_D,  0, 8'hC3, 4'h0, 21'h001000);
		add_step(0, 16'h0389, 0, 3'd0, 32'h0,          16'h0000, SND_D,  0, 8'hC3, 4'h0, 21'h002000);
		add_step(0, 16'h022A, 0, 3'd0, 32'h0,          16'h0000, SND_D,  0, 8'hC3, 4'h0, 21'h004000);
		add_step(0, 16'h03FB, 0, 3'd0, 32'h0,          16'h0000, UART_D, 0, 8'hC3, 4'h0, 21'h008000);
		add_step(0, 16'h0331, 0, 3'd0, 32'h0,          16'h0000, UART_D, 0, 8'hC3, 4'h0, 21'h010000);
		add_step(0, 16'h03B4, 0, 3'd0, 32'h0,          16'h0000, VGA_D,  0, 8'hC3, 4'h0, 21'h020000);
		add_step(0, 16'h03C5, 0, 3'd0, 32'h0,          16'h0000, VGA_D,  0, 8'hC3, 4'h0, 21'h040000);
		add_step(0, 16'h03DA, 0, 3'd0, 32'h0,          16'h0000, VGA_D,  0, 8'hC3, 4'h0, 21'h080000);
		add_step(0, 16'h0201, 0, 3'd0, 32'h0,          16'h0000, JOY_D,  0, 8'hC3, 4'h0, 21'h000008);
		add_step(0, 16'h0300, 0, 3'd0, 32'h0,          16'h0000, 32'hFF, 0, 8'hC3, 4'h0, 21'h000000);
		apply_reset();
		for (int i = 0; i < steps.size() && ok; i++)
			run_step(steps[i], ok);
		$display("checks %0d, errors %0d", checks, errors);
		if (errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// ==== hdl/io_fabric.sv ====
`timescale 1ns/1ps

module io_fabric #(
	parameter io_fabric_pkg::byte_t SYSCFG_INIT = 8'hA2
) (
	input  logic                     clk_sys,
	input  logic                     reset,

	input  io_fabric_pkg::io_addr_t  io_address,
	input  logic                     io_write,
	input  io_fabric_pkg::dsize_t    io_datasize,
	input  io_fabric_pkg::word_t     io_writedata,
	output io_fabric_pkg::word_t     io_readdata,
	output logic                     io32,
	output io_fabric_pkg::dev_sel_t  dev_sel,

	input  io_fabric_pkg::word_t     hdd0_readdata,
	input  io_fabric_pkg::word_t     hdd1_readdata,
	input  io_fabric_pkg::byte_t     floppy_readdata,
	input  io_fabric_pkg::byte_t     dma_readdata,
	input  io_fabric_pkg::byte_t     pic_readdata,
	input  io_fabric_pkg::byte_t     pit_readdata,
	input  io_fabric_pkg::byte_t     ps2_readdata,
	input  io_fabric_pkg::byte_t     rtc_readdata,
	input  io_fabric_pkg::byte_t     sound_readdata,
	input  io_fabric_pkg::byte_t     uart_readdata,
	input  io_fabric_pkg::byte_t     vga_readdata,
	input  io_fabric_pkg::byte_t     joy_readdata,

	output io_fabric_pkg::byte_t     syscfg,

	input  io_fabric_pkg::io_addr_t  mgmt_address,
	input  io_fabric_pkg::word_t     mgmt_hdd0_readdata,
	input  io_fabric_pkg::word_t     mgmt_hdd1_readdata,
	input  io_fabric_pkg::word_t     mgmt_fdd_readdata,
	output logic [3:0]               mgmt_sel,
	output io_fabric_pkg::word_t     mgmt_readdata
);

	port_decode u_port_decode (
		.clk_sys    (clk_sys),
		.io_address (io_address),
		.dev_sel    (dev_sel)
	);

	sysctl_port #(
		.SYSCFG_INIT (SYSCFG_INIT)
	) u_sysctl_port (
		.clk_sys      (clk_sys),
		.reset        (reset),
		.io_write     (io_write),
		.io_datasize  (io_datasize),
		.io_writedata (io_writedata),
		.dev_sel      (dev_sel),
		.syscfg       (syscfg)
	);

	readdata_mux u_readdata_mux (
		.io_address      (io_address),
		.dev_sel         (dev_sel),
		.hdd0_readdata   (hdd0_readdata),
		.hdd1_readdata   (hdd1_readdata),
		.floppy_readdata (floppy_readdata),
		.dma_readdata    (dma_readdata),
		.pic_readdata    (pic_readdata),
		.pit_readdata    (pit_readdata),
		.ps2_readdata    (ps2_readdata),
		.rtc_readdata    (rtc_readdata),
		.sound_readdata  (sound_readdata),
		.uart_readdata   (uart_readdata),
		.vga_readdata    (vga_readdata),
		.joy_readdata    (joy_readdata),
		.io_readdata     (io_readdata),
		.io32            (io32)
	);

	mgmt_select u_mgmt_select (
		.clk_sys            (clk_sys),
		.mgmt_address       (mgmt_address),
		.mgmt_hdd0_readdata (mgmt_hdd0_readdata),
		.mgmt_hdd1_readdata (mgmt_hdd1_readdata),
		.mgmt_fdd_readdata  (mgmt_fdd_readdata),
		.mgmt_sel           (mgmt_sel),
		.mgmt_readdata      (mgmt_readdata)
	);

endmodule

// ==== hdl/mgmt_select.sv ====
`timescale 1ns/1ps

module mgmt_select (
	input  logic                     clk_sys,
	input  io_fabric_pkg::io_addr_t  mgmt_address,
	input  io_fabric_pkg::word_t     mgmt_hdd0_readdata,
	input  io_fabric_pkg::word_t     mgmt_hdd1_readdata,
	input  io_fabric_pkg::word_t     mgmt_fdd_readdata,
	output logic [3:0]               mgmt_sel,
	output io_fabric_pkg::word_t     mgmt_readdata
);

	io_fabric_pkg::byte_t mgmt_page;

	assign mgmt_page = mgmt_address[15:8];

	// bit 0 hdd0, 1 hdd1, 2 fdd, 3 rtc
	always_ff @(posedge clk_sys) begin
		mgmt_sel[0] <= (mgmt_page == io_fabric_pkg::MGMT_HDD0);
		mgmt_sel[1] <= (mgmt_page == io_fabric_pkg::MGMT_HDD1);
		mgmt_sel[2] <= (mgmt_page == io_fabric_pkg::MGMT_FDD);
		mgmt_sel[3] <= (mgmt_page == io_fabric_pkg::MGMT_RTC);
	end

	always_comb begin
		if (mgmt_sel[0])
			mgmt_readdata = mgmt_hdd0_readdata;
		else if (mgmt_sel[1])
			mgmt_readdata = mgmt_hdd1_readdata;
		else
			mgmt_readdata = mgmt_fdd_readdata; // rtc has no readback
	end

endmodule

// ==== hdl/port_decode.sv ====
`timescale 1ns/1ps

module port_decode (
	input  logic                     clk_sys,
	input  io_fabric_pkg::io_addr_t  io_address,
	output io_fabric_pkg::dev_sel_t  dev_sel
);

	io_fabric_pkg::dev_sel_t sel_next;

	// true when addr falls in the 2**span_bits block starting at base
	function automatic logic port_hit(
		input io_fabric_pkg::io_addr_t addr,
		input io_fabric_pkg::io_addr_t base,
		input int unsigned             span_bits
	);
		io_fabric_pkg::io_addr_t mask;
		mask = 16'hFFFF << span_bits;
		return (addr & mask) == base;
	endfunction

	always_comb begin
		sel_next = '0;
		sel_next[io_fabric_pkg::SEL_HDD0] =
			port_hit(io_address, io_fabric_pkg::PORT_HDD0, 3) ||
			(io_address == io_fabric_pkg::PORT_HDD0_CTL);
		sel_next[io_fabric_pkg::SEL_HDD1] =
			port_hit(io_address, io_fabric_pkg::PORT_HDD1, 3) ||
			(io_address == io_fabric_pkg::PORT_HDD1_CTL);
		sel_next[io_fabric_pkg::SEL_JOY] =
			(io_address == io_fabric_pkg::PORT_JOY);
		sel_next[io_fabric_pkg::SEL_FLOPPY] =
			port_hit(io_address, io_fabric_pkg::PORT_FLOPPY, 3);
		sel_next[io_fabric_pkg::SEL_DMA_MASTER] =
			port_hit(io_address, io_fabric_pkg::PORT_DMA_MASTER, 5);
		sel_next[io_fabric_pkg::SEL_DMA_PAGE] =
			port_hit(io_address, io_fabric_pkg::PORT_DMA_PAGE, 4);
		sel_next[io_fabric_pkg::SEL_DMA_SLAVE] =
			port_hit(io_address, io_fabric_pkg::PORT_DMA_SLAVE, 4);
		sel_next[io_fabric_pkg::SEL_PIC_MASTER] =
			port_hit(io_address, io_fabric_pkg::PORT_PIC_MASTER, 1);
		sel_next[io_fabric_pkg::SEL_PIC_SLAVE] =
			port_hit(io_address, io_fabric_pkg::PORT_PIC_SLAVE, 1);
		sel_next[io_fabric_pkg::SEL_PIT] =
			port_hit(io_address, io_fabric_pkg::PORT_PIT, 2) ||
			(io_address == io_fabric_pkg::PORT_PIT_SPKR); // also hits ps2 io
		sel_next[io_fabric_pkg::SEL_PS2_IO] =
			port_hit(io_address, io_fabric_pkg::PORT_PS2_IO, 3);
		sel_next[io_fabric_pkg::SEL_PS2_CTL] =
			port_hit(io_address, io_fabric_pkg::PORT_PS2_CTL, 4);
		sel_next[io_fabric_pkg::SEL_RTC] =
			port_hit(io_address, io_fabric_pkg::PORT_RTC, 1);
		sel_next[io_fabric_pkg::SEL_FM] =
			port_hit(io_address, io_fabric_pkg::PORT_FM, 2);
		sel_next[io_fabric_pkg::SEL_SB] =
			port_hit(io_address, io_fabric_pkg::PORT_SB, 4);
		sel_next[io_fabric_pkg::SEL_UART] =
			port_hit(io_address, io_fabric_pkg::PORT_UART, 3);
		sel_next[io_fabric_pkg::SEL_MPU] =
			port_hit(io_address, io_fabric_pkg::PORT_MPU, 1);
		sel_next[io_fabric_pkg::SEL_VGA_B] =
			port_hit(io_address, io_fabric_pkg::PORT_VGA_B, 4);
		sel_next[io_fabric_pkg::SEL_VGA_C] =
			port_hit(io_address, io_fabric_pkg::PORT_VGA_C, 4);
		sel_next[io_fabric_pkg::SEL_VGA_D] =
			port_hit(io_address, io_fabric_pkg::PORT_VGA_D, 4);
		sel_next[io_fabric_pkg::SEL_SYSCTL] =
			(io_address == io_fabric_pkg::PORT_SYSCTL);
	end

	always_ff @(posedge clk_sys) begin
		dev_sel <= sel_next; // one cycle behind the address
	end

endmodule

// ==== hdl/readdata_mux.sv ====
`timescale 1ns/1ps

module readdata_mux (
	input  io_fabric_pkg::io_addr_t  io_address,
	input  io_fabric_pkg::dev_sel_t  dev_sel,
	input  io_fabric_pkg::word_t     hdd0_readdata,
	input  io_fabric_pkg::word_t     hdd1_readdata,
	input  io_fabric_pkg::byte_t     floppy_readdata,
	input  io_fabric_pkg::byte_t     dma_readdata,
	input  io_fabric_pkg::byte_t     pic_readdata,
	input  io_fabric_pkg::byte_t     pit_readdata,
	input  io_fabric_pkg::byte_t     ps2_readdata,
	input  io_fabric_pkg::byte_t     rtc_readdata,
	input  io_fabric_pkg::byte_t     sound_readdata,
	input  io_fabric_pkg::byte_t     uart_readdata,
	input  io_fabric_pkg::byte_t     vga_readdata,
	input  io_fabric_pkg::byte_t     joy_readdata,
	output io_fabric_pkg::word_t     io_readdata,
	output logic                     io32
);

	io_fabric_pkg::byte_t readdata8;
	logic                 hdd_sel;

	assign hdd_sel = dev_sel[io_fabric_pkg::SEL_HDD0] | dev_sel[io_fabric_pkg::SEL_HDD1];

	// byte devices in priority order
	always_comb begin
		if (dev_sel[io_fabric_pkg::SEL_FLOPPY])
			readdata8 = floppy_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_DMA_MASTER] | dev_sel[io_fabric_pkg::SEL_DMA_PAGE] |
		         dev_sel[io_fabric_pkg::SEL_DMA_SLAVE])
			readdata8 = dma_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_PIC_MASTER] | dev_sel[io_fabric_pkg::SEL_PIC_SLAVE])
			readdata8 = pic_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_PIT])
			readdata8 = pit_readdata; // wins over ps2 at 0x61
		else if (dev_sel[io_fabric_pkg::SEL_PS2_IO] | dev_sel[io_fabric_pkg::SEL_PS2_CTL])
			readdata8 = ps2_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_RTC])
			readdata8 = rtc_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_SB] | dev_sel[io_fabric_pkg::SEL_FM])
			readdata8 = sound_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_UART] | dev_sel[io_fabric_pkg::SEL_MPU])
			readdata8 = uart_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_VGA_B] | dev_sel[io_fabric_pkg::SEL_VGA_C] |
		         dev_sel[io_fabric_pkg::SEL_VGA_D])
			readdata8 = vga_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_JOY])
			readdata8 = joy_readdata;
		else
			readdata8 = 8'hFF; // open bus
	end

	always_comb begin
		if (dev_sel[io_fabric_pkg::SEL_HDD0])
			io_readdata = hdd0_readdata;
		else if (dev_sel[io_fabric_pkg::SEL_HDD1])
			io_readdata = hdd1_readdata;
		else
			io_readdata = {24'd0, readdata8};
	end

	// data ports are 32-bit, the 0x3x6 control ports are not
	assign io32 = (hdd_sel & ~io_address[9]) | dev_sel[io_fabric_pkg::SEL_SYSCTL];

endmodule

// ==== hdl/sysctl_port.sv ====
`timescale 1ns/1ps

module sysctl_port #(
	parameter io_fabric_pkg::byte_t SYSCFG_INIT = 8'hA2
) (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     io_write,
	input  io_fabric_pkg::dsize_t    io_datasize,
	input  io_fabric_pkg::word_t     io_writedata,
	input  io_fabric_pkg::dev_sel_t  dev_sel,
	output io_fabric_pkg::byte_t     syscfg
);

	io_fabric_pkg::sysctl_state_t state;
	logic                         disk_sel;
	logic                         key_write;

	assign disk_sel = dev_sel[io_fabric_pkg::SEL_HDD0] |
	                  dev_sel[io_fabric_pkg::SEL_HDD1] |
	                  dev_sel[io_fabric_pkg::SEL_FLOPPY];

	// 16-bit write to the config port carrying the unlock key
	assign key_write = io_write && dev_sel[io_fabric_pkg::SEL_SYSCTL] &&
	                   (io_datasize == 3'd2) &&
	                   (io_writedata[15:8] == io_fabric_pkg::SYSCTL_KEY);

	always_ff @(posedge clk_sys) begin
		if (reset) begin
			syscfg <= SYSCFG_INIT;
			state  <= io_fabric_pkg::ST_BOOT;
		end else if (state == io_fabric_pkg::ST_BOOT && disk_sel) begin
			syscfg <= '0; // first disk access drops the boot config
			state  <= io_fabric_pkg::ST_RUN;
		end else if (key_write) begin
			syscfg <= io_writedata[7:0];
			state  <= io_fabric_pkg::ST_RUN;
		end
	end

endmodule
